/* run.sh */
#!/bin/sh
# build and run the exec stage testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_exec -f sources.f \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_exec +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0

/* sources.f */
verilog/exm_pkg.sv
verilog/alu.sv
verilog/mul_div.sv
verilog/branch_cond.sv
verilog/agu.sv
verilog/exm_stage.sv
verilog/data_ram.sv
verilog/exec_top.sv
testbench/exec_assert.sv
testbench/tb_exec.sv

/* testbench/exec_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_assert (
    input logic                 clk,
    input logic                 reset,
    input logic                 ws_allowin,
    input logic                 es_allowin,
    input logic                 es_valid,
    input logic                 es_to_ws_valid,
    input logic                 mem_we,
    input logic                 flush_if,
    input logic                 flush_id,
    input exm_pkg::es_to_ws_t   es_to_ws_bus,
    input exm_pkg::br_t         br_bus,
    input exm_pkg::fwd_t        exm_forward_bus,
    input exm_pkg::dcache_req_t dcache_req
);
    int unsigned fail_count = 0;

    stall_hold: assert property (@(posedge clk) disable iff (reset)
        es_to_ws_valid && !ws_allowin |=> es_to_ws_valid && $stable(es_to_ws_bus)
            && $stable(br_bus) && $stable(exm_forward_bus) && $stable(flush_if))
        else begin
            fail_count++;
            $error("outputs moved during a stall");
        end

    allowin_low: assert property (@(posedge clk) disable iff (reset)
        es_valid && !ws_allowin |-> !es_allowin)
        else begin
            fail_count++;
            $error("allow-in high while stalled");
        end

    flush_valid: assert property (@(posedge clk) disable iff (reset)
        (flush_if || flush_id) |-> es_valid)
        else begin
            fail_count++;
            $error("flush from an empty stage");
        end

    no_stray_write: assert property (@(posedge clk) disable iff (reset)
        (dcache_req.be != 4'b0) |-> es_valid && ws_allowin && mem_we)
        else begin
            fail_count++;
            $error("ram write without a leaving store");
        end

    // first cycle out of reset
    reset_idle: assert property (@(posedge clk)
        $fell(reset) |-> !es_valid && !es_to_ws_valid && !flush_if && !flush_id
            && !exm_forward_bus.valid && !br_bus.pre_fail && dcache_req.be == 4'b0)
        else begin
            fail_count++;
            $error("stage not idle after reset");
        end

endmodule

bind exm_stage exec_assert u_exec_assert (
    .clk             (clk),
    .reset           (reset),
    .ws_allowin      (ws_allowin),
    .es_allowin      (es_allowin),
    .es_valid        (es_valid),
    .es_to_ws_valid  (es_to_ws_valid),
    .mem_we          (ds_r.mem_we),
    .flush_if        (flush_if),
    .flush_id        (flush_id),
    .es_to_ws_bus    (es_to_ws_bus),
    .br_bus          (br_bus),
    .exm_forward_bus (exm_forward_bus),
    .dcache_req      (dcache_req)
);

`default_nettype wire

/* testbench/tb_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exec;
    import exm_pkg::*;

    localparam int n_alu   = 120;
    localparam int n_md    = 100;
    localparam int n_fwd   = 80;
    localparam int n_init  = 16;
    localparam int n_mem   = 150;
    localparam int n_br    = 100;
    localparam int n_stall = 100;
    localparam int n_total = n_alu + n_md + n_fwd + n_init + n_mem + n_br + n_stall;

    logic        clk;
    logic        reset;
    logic        ws_allowin;
    logic        ds_to_es_valid;
    ds_to_es_t   ds_to_es_bus;
    fwd_t        forward_data1;
    fwd_t        forward_data2;
    logic        es_allowin;
    logic        es_to_ws_valid;
    es_to_ws_t   es_to_ws_bus;
    fwd_t        exm_forward_bus;
    br_t         br_bus;
    logic        flush_if;
    logic        flush_id;

    logic [31:0] seed = 32'h0657396f;
    ds_to_es_t   sent[$];
    ds_to_es_t   cur;
    logic        have_cur;
    logic        pending;
    es_to_ws_t   exp_ws;
    br_t         exp_br;
    logic [31:0] st_ea;
    logic [31:0] st_data;
    logic [31:0] mmem [ram_words];  // model copy of the data RAM
    string       test_name;
    int          stall_pct;
    logic        fwd_on;

    exec_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(n_total * 20 * 4);
        $display("timeout: the stage stopped moving instructions");
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] rnd();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {seed[15:0], seed[31:16]};  // high bits are the good ones
    endfunction

    function automatic logic [31:0] alu_ref(alu_op_t op, logic [31:0] a, logic [31:0] b);
        case (1'b1)
            op[alu_add]:  return a + b;
            op[alu_sub]:  return a - b;
            op[alu_slt]:  return {31'b0, $signed(a) < $signed(b)};
            op[alu_sltu]: return {31'b0, a < b};
            op[alu_and]:  return a & b;
            op[alu_nor]:  return ~(a | b);
            op[alu_or]:   return a | b;
            op[alu_xor]:  return a ^ b;
            op[alu_sll]:  return a << b[4:0];
            op[alu_srl]:  return a >> b[4:0];
            op[alu_sra]:  return $signed(a) >>> b[4:0];
            op[alu_lui]:  return b;
            default:      return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] md_ref(ds_to_es_t d, logic [31:0] a, logic [31:0] b);
        longint sa;
        longint sb;
        logic [63:0] p;
        sa = d.is_unsigned ? longint'({32'b0, a}) : longint'($signed(a));
        sb = d.is_unsigned ? longint'({32'b0, b}) : longint'($signed(b));
        if (d.use_div) begin
            if (b == 32'h0) begin
                return d.use_mod ? a : 32'hffff_ffff;
            end
            p = d.use_mod ? 64'(sa % sb) : 64'(sa / sb);
            return p[31:0];
        end
        p = 64'(sa * sb);
        return d.use_high ? p[63:32] : p[31:0];
    endfunction

    function automatic logic [31:0] pick(fwd_t f1, fwd_t f2, logic [4:0] r, logic [31:0] v);
        if (f1.valid && r != 5'd0 && f1.dest == r) begin
            return f1.value;
        end
        if (f2.valid && r != 5'd0 && f2.dest == r) begin
            return f2.value;
        end
        return v;
    endfunction

    task automatic compute_expected();
        logic [31:0] rj;
        logic [31:0] rk;
        logic [31:0] s1;
        logic [31:0] s2;
        logic [31:0] w;
        logic [31:0] ld;
        logic [7:0]  bv;
        logic [15:0] hv;
        logic        less;
        logic        taken;
        rj = pick(forward_data1, forward_data2, cur.rf_raddr1, cur.rj_value);
        rk = pick(forward_data1, forward_data2, cur.rf_raddr2, cur.rkd_value);
        s1 = cur.src1_is_pc ? cur.pc : rj;
        s2 = cur.src2_is_imm ? cur.imm : (cur.src2_is_4 ? 32'h4 : rk);
        st_ea   = s1 + s2;
        st_data = rk;
        w  = mmem[st_ea[9:2]];
        bv = w[st_ea[1:0]*8 +: 8];
        hv = w[st_ea[1]*16 +: 16];
        case (cur.bit_width)
            mem_byte: ld = {{24{~cur.is_unsigned & bv[7]}}, bv};
            mem_half: ld = {{16{~cur.is_unsigned & hv[15]}}, hv};
            default:  ld = w;
        endcase
        exp_ws.gr_we  = cur.gr_we;
        exp_ws.dest   = cur.dest;
        exp_ws.pc     = cur.pc;
        exp_ws.result = cur.res_from_mem ? ld
                      : (cur.use_div || cur.use_mul) ? md_ref(cur, s1, s2)
                      : alu_ref(cur.alu_op, s1, s2);
        less  = cur.is_unsigned ? (s1 < s2) : ($signed(s1) < $signed(s2));
        taken = cur.may_jump && (!cur.use_less || less == cur.need_less)
                && (!cur.use_zero || (s1 == s2) == cur.need_zero);
        exp_br.pre_fail = taken != cur.is_jump;
        exp_br.target   = taken ? ((cur.use_rj_value ? rj : cur.pc) + cur.imm) : cur.pc + 4;
    endtask

    task automatic check(input string what, input logic [127:0] expv, input logic [127:0] actv);
        assert (actv === expv) else begin
            $display("MISMATCH %s %s expected %h actual %h", test_name, what, expv, actv);
            $display("Test FAILED");
            $fatal(1, "value check");
        end
    endtask

    task automatic cycle(input logic v, input ds_to_es_t d, output logic acc);
        logic [31:0] r;
        logic        leave;
        @(negedge clk);
        if (pending) begin
            cur      = sent.pop_front();
            have_cur = 1'b1;
            pending  = 1'b0;
            r = rnd();
            forward_data1 = fwd_on ? fwd_t'({r[0], 3'b0, r[2:1], rnd()}) : '0;
            forward_data2 = fwd_on ? fwd_t'({r[3], 3'b0, r[5:4], rnd()}) : '0;
        end
        ws_allowin     = (rnd() % 100) >= stall_pct;
        ds_to_es_valid = v;
        ds_to_es_bus   = d;
        if (have_cur) begin
            compute_expected();
        end
        #1;
        check("allowin", !have_cur || ws_allowin, es_allowin);
        check("valid", have_cur, es_to_ws_valid);
        check("flush_if", have_cur && exp_br.pre_fail, flush_if);
        check("flush_id", have_cur && exp_br.pre_fail, flush_id);
        check("fwd_valid", have_cur && cur.gr_we, exm_forward_bus.valid);
        if (have_cur) begin
            check("wb", exp_ws, es_to_ws_bus);
            check("br", exp_br, br_bus);
            if (cur.gr_we) begin
                check("fwd_value", {cur.dest, exp_ws.result},
                      {exm_forward_bus.dest, exm_forward_bus.value});
            end
        end
        if (i_dut.u_exm_stage.u_exec_assert.fail_count != 0) begin
            $display("a stage property failed");
            $display("Test FAILED");
            $fatal(1, "property");
        end
        leave = have_cur && ws_allowin;
        acc   = v && es_allowin;
        @(posedge clk);
        if (leave) begin
            if (cur.mem_we) begin
                case (cur.bit_width)
                    mem_byte: mmem[st_ea[9:2]][st_ea[1:0]*8 +: 8] = st_data[7:0];
                    mem_half: mmem[st_ea[9:2]][st_ea[1]*16 +: 16] = st_data[15:0];
                    default:  mmem[st_ea[9:2]] = st_data;
                endcase
            end
            have_cur = 1'b0;
        end
        if (acc) begin
            sent.push_back(d);
            pending = 1'b1;
        end
    endtask

    function automatic ds_to_es_t gen(int kind, int k);
        ds_to_es_t   d;
        logic [31:0] r;
        logic [31:0] a;
        r = rnd();
        d = '0;
        d.alu_op    = alu_op_t'(1) << (rnd() % 12);
        d.gr_we     = 1'b1;
        d.dest      = r[12:8];
        d.rf_raddr1 = (kind == 2) ? 5'(r[14:13]) : r[20:16];
        d.rf_raddr2 = (kind == 2) ? 5'(r[16:15]) : r[25:21];
        d.rj_value  = rnd();
        d.rkd_value = rnd();
        d.imm       = rnd();
        d.pc        = rnd() & 32'hffff_fffc;
        d.src1_is_pc  = r[0];
        d.src2_is_imm = (r[2:1] == 2'd1);
        d.src2_is_4   = (r[2:1] == 2'd2);
        case (kind)
            1: begin  // mul, div and mod
                d.src2_is_imm = 1'b0;
                d.src2_is_4   = 1'b0;
                d.use_div     = r[3];
                d.use_mul     = ~r[3];
                d.use_high    = r[4];
                d.use_mod     = r[5];
                d.is_unsigned = r[6];
                if (r[27:26] == 2'd0) begin
                    d.rkd_value = 32'h0;
                end
            end
            3, 4: begin
                a = (kind == 3) ? k * 4 : rnd() % 64;
                d.alu_op       = alu_op_t'(1) << alu_add;
                d.rj_value     = 32'h0;
                d.src1_is_pc   = 1'b0;
                d.src2_is_imm  = 1'b1;
                d.src2_is_4    = 1'b0;
                d.bit_width    = (kind == 3) ? mem_word : mem_width_t'(1 << (r[4:3] % 3));
                d.imm          = (d.bit_width == mem_word) ? a & ~3
                               : (d.bit_width == mem_half) ? a & ~1 : a;
                d.mem_we       = (kind == 3) || r[5];
                d.res_from_mem = ~d.mem_we;
                d.gr_we        = ~d.mem_we;
                d.is_unsigned  = r[6];
            end
            5: begin
                d.may_jump     = 1'b1;
                d.is_jump      = r[3];
                d.use_rj_value = r[4];
                d.alu_op       = alu_op_t'(1) << alu_sub;
                if (r[5]) begin  // jirl style link
                    d.alu_op      = alu_op_t'(1) << alu_add;
                    d.src1_is_pc  = 1'b1;
                    d.src2_is_imm = 1'b0;
                    d.src2_is_4   = 1'b1;
                end else begin
                    d.gr_we       = 1'b0;
                    d.src1_is_pc  = 1'b0;
                    d.src2_is_imm = 1'b0;
                    d.src2_is_4   = 1'b0;
                    d.use_zero    = ~r[6] | r[7];
                    d.use_less    = r[6];
                    d.need_zero   = r[26];
                    d.need_less   = r[27];
                    d.is_unsigned = r[28];
                    if (r[30:29] == 2'd0) begin
                        d.rkd_value = d.rj_value;
                    end
                end
            end
            default: ;
        endcase
        return d;
    endfunction

    task automatic run_phase(string name, int kind, int count, int stall, logic fwd);
        logic      acc;
        ds_to_es_t d;
        int        kk;
        test_name = name;
        stall_pct = stall;
        fwd_on    = fwd;
        for (int i = 0; i < count; i++) begin
            kk = (kind == 6) ? 1 + 2 * (rnd() % 3) : kind;  // md, mem or branch mix
            d  = gen(kk == 3 && kind == 6 ? 4 : kk, i);
            if (rnd() % 8 == 0) begin
                cycle(1'b0, d, acc);
            end
            acc = 1'b0;
            while (!acc) begin
                cycle(1'b1, d, acc);
            end
        end
    endtask

    initial begin
        logic acc;
        reset          = 1'b1;
        ws_allowin     = 1'b0;
        ds_to_es_valid = 1'b0;
        ds_to_es_bus   = '0;
        forward_data1  = '0;
        forward_data2  = '0;
        have_cur       = 1'b0;
        pending        = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        run_phase("alu", 0, n_alu, 10, 1'b0);
        run_phase("muldiv", 1, n_md, 10, 1'b0);
        run_phase("forward", 2, n_fwd, 10, 1'b1);
        run_phase("mem_init", 3, n_init, 10, 1'b0);
        run_phase("mem", 4, n_mem, 10, 1'b0);
        run_phase("branch", 5, n_br, 10, 1'b0);
        run_phase("stall", 6, n_stall, 50, 1'b0);
        while (have_cur || pending) begin
            cycle(1'b0, ds_to_es_bus, acc);
        end
        @(negedge clk);
        if (i_dut.u_exm_stage.u_exec_assert.fail_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("Test FAILED");
            $fatal(1, "property");
        end
    end

endmodule

`default_nettype wire

/* verilog/agu.sv */
`timescale 1ns/1ps
`default_nettype none

module agu (
    input  logic                  store_fire,
    input  exm_pkg::mem_width_t   bit_width,
    input  logic                  mem_rd,
    input  logic                  is_unsigned,
    input  logic [31:0]           base,
    input  logic [31:0]           offset,
    input  logic [31:0]           wdata,
    input  exm_pkg::dcache_rsp_t  dcache_rsp,
    output exm_pkg::dcache_req_t  dcache_req,
    output logic [31:0]           mem_result
);
    import exm_pkg::*;

    logic [31:0] ea;
    load_word_u  rd;
    logic [7:0]  byte_v;
    logic [15:0] half_v;
    logic [31:0] load_v;

    assign ea = base + offset;

    always_comb begin
        dcache_req.addr  = ea[xlen-1:2];
        dcache_req.be    = 4'b0000;
        dcache_req.wdata = wdata;
        case (bit_width)
            mem_byte: begin
                dcache_req.be    = 4'b0001 << ea[1:0];
                dcache_req.wdata = {4{wdata[7:0]}};  // replicate to every lane
            end
            mem_half: begin
                dcache_req.be    = ea[1] ? 4'b1100 : 4'b0011;
                dcache_req.wdata = {2{wdata[15:0]}};
            end
            mem_word: begin
                dcache_req.be    = 4'b1111;
            end
            default: begin
                dcache_req.be    = 4'b0000;
            end
        endcase
        if (!store_fire) begin
            dcache_req.be = 4'b0000;
        end
    end

    assign rd     = dcache_rsp.rdata;
    assign byte_v = rd.lane[ea[1:0]];
    assign half_v = {rd.lane[{ea[1], 1'b1}], rd.lane[{ea[1], 1'b0}]};

    always_comb begin
        case (bit_width)
            mem_byte: load_v = {{24{~is_unsigned & byte_v[7]}}, byte_v};
            mem_half: load_v = {{16{~is_unsigned & half_v[15]}}, half_v};
            mem_word: load_v = rd.word;
            default:  load_v = 32'h0;
        endcase
    end

    assign mem_result = (mem_rd && dcache_rsp.ready && dcache_rsp.rvalid) ? load_v : 32'h0;

endmodule

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  exm_pkg::alu_op_t alu_op,
    input  logic [31:0]      alu_src1,
    input  logic [31:0]      alu_src2,
    input  logic             is_unsigned,
    output logic [31:0]      alu_result,
    output logic             zero,
    output logic             less
);
    import exm_pkg::*;

    logic [31:0] add_res;
    logic [32:0] sub_ext;
    logic        slt_res;
    logic        sltu_res;
    logic [31:0] sra_res;

    assign add_res  = alu_src1 + alu_src2;
    assign sub_ext  = {1'b0, alu_src1} - {1'b0, alu_src2};
    assign sltu_res = sub_ext[32];  // borrow out
    assign slt_res  = (alu_src1[31] & ~alu_src2[31])
                    | (~(alu_src1[31] ^ alu_src2[31]) & sub_ext[31]);
    assign sra_res  = $signed(alu_src1) >>> alu_src2[4:0];

    assign zero = (sub_ext[31:0] == 32'h0);
    assign less = is_unsigned ? sltu_res : slt_res;

    // one-hot and-or select
    assign alu_result = ({32{alu_op[alu_add]}}  & add_res)
                      | ({32{alu_op[alu_sub]}}  & sub_ext[31:0])
                      | ({32{alu_op[alu_slt]}}  & {31'b0, slt_res})
                      | ({32{alu_op[alu_sltu]}} & {31'b0, sltu_res})
                      | ({32{alu_op[alu_and]}}  & (alu_src1 & alu_src2))
                      | ({32{alu_op[alu_nor]}}  & ~(alu_src1 | alu_src2))
                      | ({32{alu_op[alu_or]}}   & (alu_src1 | alu_src2))
                      | ({32{alu_op[alu_xor]}}  & (alu_src1 ^ alu_src2))
                      | ({32{alu_op[alu_sll]}}  & (alu_src1 << alu_src2[4:0]))
                      | ({32{alu_op[alu_srl]}}  & (alu_src1 >> alu_src2[4:0]))
                      | ({32{alu_op[alu_sra]}}  & sra_res)
                      | ({32{alu_op[alu_lui]}}  & alu_src2);  // imm already shifted

endmodule

`default_nettype wire

/* verilog/branch_cond.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_cond (
    input  logic          es_valid,
    input  logic          pre_jump,
    input  logic          may_jump,
    input  logic          use_rj_value,
    input  logic          use_less,
    input  logic          need_less,
    input  logic          use_zero,
    input  logic          need_zero,
    input  logic          less,
    input  logic          zero,
    input  logic [31:0]   pc,
    input  logic [31:0]   rj_value,
    input  logic [31:0]   imm,
    output exm_pkg::br_t  br,
    output logic          flush_if,
    output logic          flush_id
);
    logic        taken;
    logic [31:0] jump_target;
    logic        mispredict;

    assign taken = may_jump
                 & (~use_less | (less == need_less))
                 & (~use_zero | (zero == need_zero));

    assign jump_target = (use_rj_value ? rj_value : pc) + imm;
    assign mispredict  = es_valid & (taken != pre_jump);

    assign br.pre_fail = mispredict;
    // not-taken correction falls through
    assign br.target   = !es_valid ? 32'h0
                       : taken     ? jump_target
                       : pc + 32'h4;

    assign flush_if = mispredict;
    assign flush_id = mispredict;

endmodule

`default_nettype wire

/* verilog/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram (
    input  logic                  clk,
    input  exm_pkg::dcache_req_t  dcache_req,
    output exm_pkg::dcache_rsp_t  dcache_rsp
);
    import exm_pkg::*;

    logic [xlen-1:0]       mem [ram_words];
    logic [ram_addr_w-1:0] idx;

    assign idx = dcache_req.addr[ram_addr_w-1:0];  // wraps above depth

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (dcache_req.be[i]) begin
                mem[idx][i*8 +: 8] <= dcache_req.wdata[i*8 +: 8];
            end
        end
    end

    assign dcache_rsp.ready  = 1'b1;
    assign dcache_rsp.rvalid = 1'b1;
    assign dcache_rsp.rdata  = mem[idx];  // async read

endmodule

`default_nettype wire

/* verilog/exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                ws_allowin,
    input  logic                ds_to_es_valid,
    input  exm_pkg::ds_to_es_t  ds_to_es_bus,
    input  exm_pkg::fwd_t       forward_data1,
    input  exm_pkg::fwd_t       forward_data2,
    output logic                es_allowin,
    output logic                es_to_ws_valid,
    output exm_pkg::es_to_ws_t  es_to_ws_bus,
    output exm_pkg::fwd_t       exm_forward_bus,
    output exm_pkg::br_t        br_bus,
    output logic                flush_if,
    output logic                flush_id
);
    import exm_pkg::*;

    dcache_req_t dcache_req;
    dcache_rsp_t dcache_rsp;

    exm_stage u_exm_stage (
        .clk             (clk),
        .reset           (reset),
        .ws_allowin      (ws_allowin),
        .es_allowin      (es_allowin),
        .ds_to_es_valid  (ds_to_es_valid),
        .ds_to_es_bus    (ds_to_es_bus),
        .forward_data1   (forward_data1),
        .forward_data2   (forward_data2),
        .exm_forward_bus (exm_forward_bus),
        .br_bus          (br_bus),
        .es_to_ws_valid  (es_to_ws_valid),
        .es_to_ws_bus    (es_to_ws_bus),
        .flush_if        (flush_if),
        .flush_id        (flush_id),
        .dcache_rsp      (dcache_rsp),
        .dcache_req      (dcache_req)
    );

    data_ram u_data_ram (
        .clk        (clk),
        .dcache_req (dcache_req),
        .dcache_rsp (dcache_rsp)
    );

endmodule

`default_nettype wire

/* verilog/exm_pkg.sv */
`default_nettype none

package exm_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int ram_words  = 256;
    localparam int ram_addr_w = $clog2(ram_words);

    // one-hot alu operation positions
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    typedef logic [11:0] alu_op_t;

    // access width codes with zero as no access
    typedef logic [3:0] mem_width_t;
    localparam mem_width_t mem_byte = 4'h1;
    localparam mem_width_t mem_half = 4'h2;
    localparam mem_width_t mem_word = 4'h4;

    typedef struct packed {
        alu_op_t                alu_op;
        mem_width_t             bit_width;
        logic                   may_jump;
        logic                   use_rj_value;  // absolute jump
        logic                   use_less;
        logic                   need_less;
        logic                   use_zero;
        logic                   need_zero;
        logic                   src1_is_pc;
        logic                   src2_is_imm;
        logic                   src2_is_4;
        logic                   gr_we;
        logic                   mem_we;
        logic [reg_addr_w-1:0]  dest;
        logic [xlen-1:0]        imm;
        logic [reg_addr_w-1:0]  rf_raddr1;
        logic [reg_addr_w-1:0]  rf_raddr2;
        logic [xlen-1:0]        rj_value;
        logic [xlen-1:0]        rkd_value;
        logic [xlen-1:0]        pc;
        logic                   is_jump;  // predicted taken
        logic                   res_from_mem;
        logic                   use_mul;
        logic                   use_high;
        logic                   is_unsigned;
        logic                   use_div;
        logic                   use_mod;
    } ds_to_es_t;

    typedef struct packed {
        logic                   gr_we;
        logic [reg_addr_w-1:0]  dest;
        logic [xlen-1:0]        result;
        logic [xlen-1:0]        pc;
    } es_to_ws_t;

    typedef struct packed {
        logic                   valid;
        logic [reg_addr_w-1:0]  dest;
        logic [xlen-1:0]        value;
    } fwd_t;

    typedef struct packed {
        logic                   pre_fail;
        logic [xlen-1:0]        target;
    } br_t;

    typedef struct packed {
        logic [xlen-3:0]        addr;  // word address
        logic [3:0]             be;
        logic [xlen-1:0]        wdata;
    } dcache_req_t;

    typedef struct packed {
        logic                   ready;
        logic                   rvalid;
        logic [xlen-1:0]        rdata;
    } dcache_rsp_t;

    typedef union packed {
        logic [xlen-1:0]        word;
        logic [3:0][7:0]        lane;
    } load_word_u;

endpackage

`default_nettype wire

/* verilog/exm_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module exm_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ws_allowin,
    output logic                  es_allowin,
    input  logic                  ds_to_es_valid,
    input  exm_pkg::ds_to_es_t    ds_to_es_bus,
    input  exm_pkg::fwd_t         forward_data1,
    input  exm_pkg::fwd_t         forward_data2,
    output exm_pkg::fwd_t         exm_forward_bus,
    output exm_pkg::br_t          br_bus,
    output logic                  es_to_ws_valid,
    output exm_pkg::es_to_ws_t    es_to_ws_bus,
    output logic                  flush_if,
    output logic                  flush_id,
    input  exm_pkg::dcache_rsp_t  dcache_rsp,
    output exm_pkg::dcache_req_t  dcache_req
);
    import exm_pkg::*;

    logic            es_valid;
    ds_to_es_t       ds_r;
    logic [xlen-1:0] rj_value;
    logic [xlen-1:0] rkd_value;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] md_result;
    logic [xlen-1:0] mem_result;
    logic [xlen-1:0] final_result;
    logic            zero;
    logic            less;
    logic            store_fire;

    // later stage wins and r0 is never forwarded
    function automatic logic [xlen-1:0] fwd_pick(
        input fwd_t                  f1,
        input fwd_t                  f2,
        input logic [reg_addr_w-1:0] raddr,
        input logic [xlen-1:0]       bus_value
    );
        logic hit1;
        logic hit2;
        hit1 = f1.valid && (f1.dest != '0) && (f1.dest == raddr);
        hit2 = f2.valid && (f2.dest != '0) && (f2.dest == raddr);
        if (hit1) begin
            return f1.value;
        end
        if (hit2) begin
            return f2.value;
        end
        return bus_value;
    endfunction

    // single-cycle ops, so the stage is always ready
    assign es_allowin     = !es_valid || ws_allowin;
    assign es_to_ws_valid = es_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_to_es_valid && es_allowin) begin
            ds_r <= ds_to_es_bus;
        end
    end

    assign rj_value  = fwd_pick(forward_data1, forward_data2, ds_r.rf_raddr1, ds_r.rj_value);
    assign rkd_value = fwd_pick(forward_data1, forward_data2, ds_r.rf_raddr2, ds_r.rkd_value);

    assign src1 = ds_r.src1_is_pc ? ds_r.pc : rj_value;
    assign src2 = ds_r.src2_is_imm ? ds_r.imm
                : ds_r.src2_is_4   ? 32'h4
                : rkd_value;

    alu u_alu (
        .alu_op      (ds_r.alu_op),
        .alu_src1    (src1),
        .alu_src2    (src2),
        .is_unsigned (ds_r.is_unsigned),
        .alu_result  (alu_result),
        .zero        (zero),
        .less        (less)
    );

    mul_div u_mul_div (
        .use_mul     (ds_r.use_mul),
        .use_div     (ds_r.use_div),
        .use_high    (ds_r.use_high),
        .use_mod     (ds_r.use_mod),
        .is_unsigned (ds_r.is_unsigned),
        .src1        (src1),
        .src2        (src2),
        .result      (md_result)
    );

    // store writes once at the leaving edge
    assign store_fire = es_to_ws_valid && ws_allowin && ds_r.mem_we;

    agu u_agu (
        .store_fire  (store_fire),
        .bit_width   (ds_r.bit_width),
        .mem_rd      (ds_r.res_from_mem),
        .is_unsigned (ds_r.is_unsigned),
        .base        (src1),
        .offset      (src2),
        .wdata       (rkd_value),
        .dcache_rsp  (dcache_rsp),
        .dcache_req  (dcache_req),
        .mem_result  (mem_result)
    );

    branch_cond u_branch (
        .es_valid     (es_valid),
        .pre_jump     (ds_r.is_jump),
        .may_jump     (ds_r.may_jump),
        .use_rj_value (ds_r.use_rj_value),
        .use_less     (ds_r.use_less),
        .need_less    (ds_r.need_less),
        .use_zero     (ds_r.use_zero),
        .need_zero    (ds_r.need_zero),
        .less         (less),
        .zero         (zero),
        .pc           (ds_r.pc),
        .rj_value     (rj_value),
        .imm          (ds_r.imm),
        .br           (br_bus),
        .flush_if     (flush_if),
        .flush_id     (flush_id)
    );

    assign final_result = ds_r.res_from_mem            ? mem_result
                        : (ds_r.use_div | ds_r.use_mul) ? md_result
                        : alu_result;

    assign es_to_ws_bus.gr_we  = ds_r.gr_we;
    assign es_to_ws_bus.dest   = ds_r.dest;
    assign es_to_ws_bus.result = final_result;
    assign es_to_ws_bus.pc     = ds_r.pc;

    assign exm_forward_bus.valid = es_valid && ds_r.gr_we;
    assign exm_forward_bus.dest  = ds_r.dest;
    assign exm_forward_bus.value = final_result;

endmodule

`default_nettype wire

/* verilog/mul_div.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_div (
    input  logic        use_mul,
    input  logic        use_div,
    input  logic        use_high,
    input  logic        use_mod,
    input  logic        is_unsigned,
    input  logic [31:0] src1,
    input  logic [31:0] src2,
    output logic [31:0] result
);
    logic signed [32:0] a_ext;
    logic signed [32:0] b_ext;
    logic signed [65:0] prod;
    logic [31:0]        mul_res;
    logic               neg1;
    logic               neg2;
    logic [31:0]        mag1;
    logic [31:0]        mag2;
    logic [31:0]        q_mag;
    logic [31:0]        r_mag;
    logic [31:0]        quot;
    logic [31:0]        rem;

    // 33-bit operands cover both signednesses
    assign a_ext   = {~is_unsigned & src1[31], src1};
    assign b_ext   = {~is_unsigned & src2[31], src2};
    assign prod    = a_ext * b_ext;
    assign mul_res = use_high ? prod[63:32] : prod[31:0];

    assign neg1  = ~is_unsigned & src1[31];
    assign neg2  = ~is_unsigned & src2[31];
    assign mag1  = neg1 ? -src1 : src1;
    assign mag2  = neg2 ? -src2 : src2;
    assign q_mag = (mag2 == 32'h0) ? 32'h0 : mag1 / mag2;
    assign r_mag = (mag2 == 32'h0) ? 32'h0 : mag1 % mag2;

    // zero divisor gives all ones and the dividend
    assign quot = (src2 == 32'h0) ? 32'hffff_ffff : ((neg1 ^ neg2) ? -q_mag : q_mag);
    assign rem  = (src2 == 32'h0) ? src1 : (neg1 ? -r_mag : r_mag);

    assign result = use_div ? (use_mod ? rem : quot)
                  : use_mul ? mul_res
                  : 32'h0;

endmodule

`default_nettype wire
